//--- files.f
logic/eink_pkg.sv
logic/cmd_rom.sv
logic/pattern_gen.sv
logic/delay_timer.sv
logic/spi_byte_tx.sv
logic/eink_ctrl.sv
logic/eink_driver_top.sv
tb/eink_tb.sv

//--- logic/cmd_rom.sv
// SSD1680 init and tail byte tables with command and end-of-transmission marks
`default_nettype none
`timescale 1ns/1ps

module cmd_rom (
    input  eink_pkg::rom_idx_t rom_idx,
    input  wire                rom_tail,    // Tail table selected
    output eink_pkg::byte_t    rom_byte,
    output logic               rom_last,    // Byte ends its transmission
    output logic               rom_is_cmd   // Sent with dc low
);

    always_comb begin
        rom_byte   = 8'h00;
        rom_last   = 1'b0;
        rom_is_cmd = 1'b0;
        if (rom_tail) begin
            case (rom_idx)
                5'd0:    rom_byte = 8'h22;  // Display update control 2
                5'd1:    rom_byte = 8'hF4;
                5'd2:    rom_byte = 8'h20;  // Master activate, then busy wait
                5'd3:    rom_byte = 8'h10;  // Deep sleep
                default: rom_byte = 8'h01;
            endcase
            rom_is_cmd = (rom_idx == 5'd0) || (rom_idx == 5'd2) || (rom_idx == 5'd3);
            rom_last   = (rom_idx == 5'd1) || (rom_idx == 5'd2) || (rom_idx == 5'd4);
        end else begin
            case (rom_idx)
                5'd0:  rom_byte = 8'h11;  // Data entry mode
                5'd1:  rom_byte = 8'h03;
                5'd2:  rom_byte = 8'h3C;  // Border waveform
                5'd3:  rom_byte = 8'h05;
                5'd4:  rom_byte = 8'h2C;  // VCOM
                5'd5:  rom_byte = 8'h36;
                5'd6:  rom_byte = 8'h03;  // Gate voltage
                5'd7:  rom_byte = 8'h17;
                5'd8:  rom_byte = 8'h04;  // Source voltage
                5'd9:  rom_byte = 8'h41;
                5'd11: rom_byte = 8'h32;
                5'd12: rom_byte = 8'h4E;  // RAM X counter
                5'd14: rom_byte = 8'h4F;  // RAM Y counter
                5'd17: rom_byte = 8'h44;  // RAM X window
                5'd19: rom_byte = 8'h0F;
                5'd20: rom_byte = 8'h45;  // RAM Y window
                5'd23: rom_byte = 8'hF9;
                5'd25: rom_byte = 8'h01;  // Driver output control
                5'd26: rom_byte = 8'hF9;
                5'd29: rom_byte = 8'h24;  // Write RAM, pixels follow
                default: rom_byte = 8'h00;
            endcase
            case (rom_idx)
                5'd0, 5'd2, 5'd4, 5'd6, 5'd8, 5'd12,
                5'd14, 5'd17, 5'd20, 5'd25, 5'd29: rom_is_cmd = 1'b1;
                default: rom_is_cmd = 1'b0;
            endcase
            // 0x24 keeps the frame open for the pixel stream
            case (rom_idx)
                5'd1, 5'd3, 5'd5, 5'd7, 5'd11,
                5'd13, 5'd16, 5'd19, 5'd24, 5'd28: rom_last = 1'b1;
                default: rom_last = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/delay_timer.sv
// Two-level down counter for reset pulse and settle delays
`default_nettype none
`timescale 1ns/1ps

module delay_timer #(
    parameter int DELAY_TICKS = 32767,
    parameter int DELAY_LOOPS = 16
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  dly_start,
    output logic dly_done   // One cycle, TICKS*LOOPS after start
);

    localparam int TW = (DELAY_TICKS > 1) ? $clog2(DELAY_TICKS) : 1;
    localparam int LW = (DELAY_LOOPS > 1) ? $clog2(DELAY_LOOPS) : 1;

    logic [TW-1:0] tick_cnt;
    logic [LW-1:0] loop_cnt;
    logic          running;

    assign dly_done = running && tick_cnt == '0 && loop_cnt == '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            loop_cnt <= '0;
            running  <= 1'b0;
        end else if (dly_start) begin  // Restarts a running delay too
            tick_cnt <= TW'(DELAY_TICKS - 1);
            loop_cnt <= LW'(DELAY_LOOPS - 1);
            running  <= 1'b1;
        end else if (running) begin
            if (tick_cnt != '0) begin
                tick_cnt <= tick_cnt - 1'b1;
            end else if (loop_cnt != '0) begin
                tick_cnt <= TW'(DELAY_TICKS - 1);  // Next outer loop
                loop_cnt <= loop_cnt - 1'b1;
            end else begin
                running <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/eink_ctrl.sv
// Refresh sequencer FSM with selection sync, byte handshake, pixel counter and panel pins
`default_nettype none
`timescale 1ns/1ps

module eink_ctrl #(
    parameter int DISPLAY_BYTES = 4000
) (
    input  wire                clk,
    input  wire                rst_n,
    input  eink_pkg::pat_sel_t pat_sel,
    input  wire                panel_busy,
    input  wire                tx_busy,
    input  eink_pkg::byte_t    rom_byte,
    input  wire                rom_last,
    input  wire                rom_is_cmd,
    input  eink_pkg::byte_t    pix_byte,
    input  wire                dly_done,
    output eink_pkg::byte_t    tx_byte,
    output logic               tx_start,
    output logic               tx_frame,
    output eink_pkg::rom_idx_t rom_idx,
    output logic               rom_tail,
    output eink_pkg::addr_t    pix_addr,
    output eink_pkg::pat_sel_t pat_latched,
    output logic               dly_start,
    output logic               panel_dc,
    output logic               panel_rst_n
);
    import eink_pkg::*;

    ctrl_state_t state;
    pat_sel_t    pat_meta;   // First sync stage
    pat_sel_t    pat_sync;   // Second sync stage
    logic        sent;       // Byte handed to the shifter, not yet finished
    logic        send_state;
    logic        issue;
    logic        byte_done;
    byte_t       next_byte;
    logic        next_cmd;

    assign send_state = (state == ST_SOFT_RESET) || (state == ST_INIT_SEND) ||
                        (state == ST_PIXEL_SEND) || (state == ST_TAIL_SEND);
    assign issue      = send_state && !sent && !tx_busy;
    // tx_busy only rises a cycle after the start pulse
    assign byte_done  = sent && !tx_start && !tx_busy;
    assign rom_tail   = (state == ST_TAIL_SEND) || (state == ST_TAIL_BUSY);

    always_comb begin
        case (state)
            ST_SOFT_RESET: begin
                next_byte = CMD_SOFT_RESET;
                next_cmd  = 1'b1;
            end
            ST_PIXEL_SEND: begin
                next_byte = pix_byte;            // Pixels are always data
                next_cmd  = 1'b0;
            end
            default: begin
                next_byte = rom_byte;
                next_cmd  = rom_is_cmd;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (issue) tx_byte <= next_byte;         // Held for the whole byte
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            pat_meta    <= '0;
            pat_sync    <= '0;
            pat_latched <= '0;
            sent        <= 1'b0;
            tx_start    <= 1'b0;
            tx_frame    <= 1'b0;
            rom_idx     <= '0;
            pix_addr    <= '0;
            dly_start   <= 1'b0;
            panel_dc    <= 1'b1;
            panel_rst_n <= 1'b1;                 // Panel not in reset
        end else begin
            pat_meta  <= pat_sel;
            pat_sync  <= pat_meta;
            tx_start  <= 1'b0;                   // Single-cycle pulses
            dly_start <= 1'b0;

            if (issue) begin
                panel_dc <= !next_cmd;
                tx_frame <= 1'b1;
                tx_start <= 1'b1;
                sent     <= 1'b1;
            end
            if (byte_done) sent <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (pat_sync != '0 && pat_sync != pat_latched) begin
                        pat_latched <= pat_sync;
                        state       <= ST_HW_RESET;
                    end
                end
                ST_HW_RESET: begin
                    panel_rst_n <= 1'b0;
                    dly_start   <= 1'b1;
                    state       <= ST_RESET_DELAY;
                end
                ST_RESET_DELAY: begin
                    // First delay is the pulse, second the recovery
                    if (dly_done && !panel_rst_n) begin
                        panel_rst_n <= 1'b1;
                        dly_start   <= 1'b1;
                    end else if (dly_done) begin
                        state <= ST_SOFT_RESET;
                    end
                end
                ST_SOFT_RESET: begin
                    if (byte_done) begin
                        tx_frame <= 1'b0;        // Single-byte transmission
                        state    <= ST_WAIT_BUSY;
                    end
                end
                ST_WAIT_BUSY: begin
                    if (!panel_busy) begin
                        dly_start <= 1'b1;
                        state     <= ST_IDLE_DELAY;
                    end
                end
                ST_IDLE_DELAY: begin
                    if (dly_done) begin
                        rom_idx <= '0;
                        state   <= ST_INIT_SEND;
                    end
                end
                ST_INIT_SEND: begin
                    if (byte_done) begin
                        if (rom_last) tx_frame <= 1'b0;
                        if (rom_idx == rom_idx_t'(INIT_LEN - 1)) begin
                            pix_addr <= '0;      // 0x24 frame carries on into pixels
                            state    <= ST_PIXEL_SEND;
                        end else begin
                            rom_idx <= rom_idx + 1'b1;
                        end
                    end
                end
                ST_PIXEL_SEND: begin
                    if (byte_done) begin
                        if (pix_addr == addr_t'(DISPLAY_BYTES - 1)) begin
                            tx_frame <= 1'b0;
                            rom_idx  <= '0;
                            state    <= ST_TAIL_SEND;
                        end else begin
                            pix_addr <= pix_addr + 1'b1;
                        end
                    end
                end
                ST_TAIL_SEND: begin
                    if (byte_done) begin
                        if (rom_last) tx_frame <= 1'b0;
                        rom_idx <= rom_idx + 1'b1;
                        // Only master activate is a command closing its own frame
                        if (rom_last && rom_is_cmd) state <= ST_TAIL_BUSY;
                        else if (rom_idx == rom_idx_t'(TAIL_LEN - 1)) state <= ST_IDLE;
                    end
                end
                ST_TAIL_BUSY: begin
                    if (!panel_busy) state <= ST_TAIL_SEND;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Shifter must be idle when a byte is handed over
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy);
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
                                   pix_addr < addr_t'(DISPLAY_BYTES));

endmodule

`default_nettype wire

//--- logic/eink_driver_top.sv
// E-ink driver top level joining sequencer, SPI shifter, command tables, patterns and delay
`default_nettype none
`timescale 1ns/1ps

module eink_driver_top #(
    parameter int DISPLAY_BYTES = 4000,   // Bytes in one full frame
    parameter int DELAY_TICKS   = 32767,  // Inner delay count
    parameter int DELAY_LOOPS   = 16,     // Outer delay count
    parameter int SCK_DIV       = 2       // clk cycles per SCK half period
) (
    input  wire                clk,
    input  wire                rst_n,
    input  eink_pkg::pat_sel_t pat_sel,      // Pattern request from user
    input  wire                panel_busy,   // High while panel is working
    output logic               spi_sck,
    output logic               spi_mosi,
    output logic               spi_csb,
    output logic               panel_dc,     // Low for command bytes
    output logic               panel_rst_n   // Panel hardware reset
);
    import eink_pkg::*;

    byte_t    tx_byte;
    logic     tx_start;
    logic     tx_frame;
    logic     tx_busy;
    rom_idx_t rom_idx;
    logic     rom_tail;
    byte_t    rom_byte;
    logic     rom_last;
    logic     rom_is_cmd;
    addr_t    pix_addr;
    pat_sel_t pat_latched;
    byte_t    pix_byte;
    logic     dly_start;
    logic     dly_done;

    eink_ctrl #(.DISPLAY_BYTES(DISPLAY_BYTES)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .pat_sel(pat_sel), .panel_busy(panel_busy),
        .tx_busy(tx_busy), .rom_byte(rom_byte), .rom_last(rom_last),
        .rom_is_cmd(rom_is_cmd), .pix_byte(pix_byte), .dly_done(dly_done),
        .tx_byte(tx_byte), .tx_start(tx_start), .tx_frame(tx_frame),
        .rom_idx(rom_idx), .rom_tail(rom_tail), .pix_addr(pix_addr),
        .pat_latched(pat_latched), .dly_start(dly_start),
        .panel_dc(panel_dc), .panel_rst_n(panel_rst_n)
    );

    spi_byte_tx #(.SCK_DIV(SCK_DIV)) u_spi (
        .clk(clk), .rst_n(rst_n), .tx_byte(tx_byte), .tx_start(tx_start),
        .tx_frame(tx_frame), .tx_busy(tx_busy), .spi_sck(spi_sck),
        .spi_mosi(spi_mosi), .spi_csb(spi_csb)
    );

    cmd_rom u_rom (
        .rom_idx(rom_idx), .rom_tail(rom_tail), .rom_byte(rom_byte),
        .rom_last(rom_last), .rom_is_cmd(rom_is_cmd)
    );

    pattern_gen u_pat (.pix_addr(pix_addr), .pat_latched(pat_latched), .pix_byte(pix_byte));

    delay_timer #(.DELAY_TICKS(DELAY_TICKS), .DELAY_LOOPS(DELAY_LOOPS)) u_dly (
        .clk(clk), .rst_n(rst_n), .dly_start(dly_start), .dly_done(dly_done)
    );

endmodule

`default_nettype wire

//--- logic/eink_pkg.sv
// Widths, typedefs, sequencer states, opcodes and pattern bits for the e-ink driver
`default_nettype none

package eink_pkg;

    typedef logic [7:0]  byte_t;     // One SPI byte
    typedef logic [15:0] addr_t;     // Display byte address, up to 4000 bytes
    typedef logic [5:0]  pat_sel_t;  // One bit per pattern
    typedef logic [4:0]  rom_idx_t;  // Index into init or tail table

    typedef enum logic [3:0] {
        ST_IDLE,         // Waiting for a new selection
        ST_HW_RESET,     // Pull panel reset low
        ST_RESET_DELAY,  // Reset pulse, then recovery delay
        ST_SOFT_RESET,   // Send 0x12
        ST_WAIT_BUSY,    // Panel busy after soft reset
        ST_IDLE_DELAY,   // Settle after soft reset
        ST_INIT_SEND,    // 30-byte init table
        ST_PIXEL_SEND,   // Pixel stream
        ST_TAIL_SEND,    // Update and deep-sleep bytes
        ST_TAIL_BUSY     // Panel busy after master activate
    } ctrl_state_t;

    localparam byte_t CMD_SOFT_RESET = 8'h12;  // SSD1680 software reset

    localparam int INIT_LEN = 30;  // Init table length
    localparam int TAIL_LEN = 5;   // Tail table length

    // Bit positions in the pattern selection, lowest set bit wins
    localparam int PAT_WHITE   = 0;
    localparam int PAT_BLACK   = 1;
    localparam int PAT_VSTRIPE = 2;
    localparam int PAT_HSTRIPE = 3;
    localparam int PAT_CHECK_S = 4;
    localparam int PAT_CHECK_L = 5;

endpackage

`default_nettype wire

//--- logic/pattern_gen.sv
// Pixel byte generator from byte address and latched pattern selection
`default_nettype none
`timescale 1ns/1ps

module pattern_gen (
    input  eink_pkg::addr_t    pix_addr,
    input  eink_pkg::pat_sel_t pat_latched,
    output eink_pkg::byte_t    pix_byte
);
    import eink_pkg::*;

    // Address bits 3:0 run down a column, upper bits across
    always_comb begin
        if (pat_latched[PAT_WHITE])
            pix_byte = 8'hFF;
        else if (pat_latched[PAT_BLACK])
            pix_byte = 8'h00;
        else if (pat_latched[PAT_VSTRIPE])
            pix_byte = {8{pix_addr[7]}};
        else if (pat_latched[PAT_HSTRIPE])
            pix_byte = {8{pix_addr[0]}};
        else if (pat_latched[PAT_CHECK_S])
            pix_byte = {8{pix_addr[0] ^ pix_addr[6]}};
        else if (pat_latched[PAT_CHECK_L])
            pix_byte = {8{pix_addr[2] ^ pix_addr[8]}};
        else
            pix_byte = 8'hFF;  // Blank when nothing selected
    end

endmodule

`default_nettype wire

//--- logic/spi_byte_tx.sv
// Mode-0 MSB-first SPI byte shifter with prescaled SCK and frame-held chip select
`default_nettype none
`timescale 1ns/1ps

module spi_byte_tx #(
    parameter int SCK_DIV = 2  // clk cycles per SCK half period
) (
    input  wire             clk,
    input  wire             rst_n,
    input  eink_pkg::byte_t tx_byte,
    input  wire             tx_start,   // One-cycle request
    input  wire             tx_frame,   // Keep csb low between bytes
    output logic            tx_busy,
    output logic            spi_sck,
    output logic            spi_mosi,
    output logic            spi_csb
);
    import eink_pkg::*;

    localparam int DW = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;

    logic [DW-1:0] div_cnt;   // Prescaler
    logic [3:0]    half_cnt;  // SCK half periods, 16 per byte
    byte_t         shreg;

    assign spi_mosi = shreg[7];  // MSB first

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy  <= 1'b0;
            spi_sck  <= 1'b0;  // Mode 0 idles low
            spi_csb  <= 1'b1;
            div_cnt  <= '0;
            half_cnt <= '0;
            shreg    <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy  <= 1'b1;
                spi_csb  <= 1'b0;
                shreg    <= tx_byte;  // Bit 7 on MOSI before the first rise
                div_cnt  <= '0;
                half_cnt <= '0;
            end else begin
                spi_csb <= !tx_frame;  // Rises once the frame is released
            end
        end else if (div_cnt == DW'(SCK_DIV - 1)) begin
            div_cnt  <= '0;
            spi_sck  <= !spi_sck;
            half_cnt <= half_cnt + 1'b1;
            if (spi_sck) begin
                shreg <= {shreg[6:0], 1'b0};  // MOSI changes on the fall
                if (half_cnt == 4'd15) tx_busy <= 1'b0;  // Eighth bit done
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    a_csb_busy: assert property (@(posedge clk) disable iff (!rst_n) tx_busy |-> !spi_csb);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the e-ink driver testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module eink_tb -f files.f -o eink_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/eink_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$SIM_LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $SIM_LOG"
exit 1

//--- tb/eink_tb.sv
// Testbench for the e-ink driver with SPI byte receiver, busy model, vector reader and checks
`default_nettype none
`timescale 1ns/1ps

module eink_tb;
    import eink_pkg::*;

    localparam int DISPLAY_BYTES = 512;     // Shortened frame, still reaches address bit 8
    localparam int DELAY_TICKS   = 4;
    localparam int DELAY_LOOPS   = 2;
    localparam int SCK_DIV       = 2;
    localparam int QUIET_CYCLES  = 400;     // Window with no SPI traffic expected
    localparam int RX_MAX        = 4096;    // Received byte store
    localparam int VEC_MAX       = 64;      // Words in the vector file
    localparam byte_t SOFT_RESET_BYTE = 8'h12;

    logic     clk;
    logic     rst_n;
    pat_sel_t pat_sel;
    logic     panel_busy;
    logic     spi_sck;
    logic     spi_mosi;
    logic     spi_csb;
    logic     panel_dc;
    logic     panel_rst_n;

    byte_t       rx_data [0:RX_MAX-1];     // Received bytes in order
    logic        rx_dc   [0:RX_MAX-1];     // dc seen on the eighth bit
    logic        rx_end  [0:RX_MAX-1];     // csb rose after this byte
    int          rx_count = 0;
    int          rx_rd = 0;                // Next byte to compare
    int          rst_pulses = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] lcg_state = 32'h1fc5936f;
    logic        exp_end_q [$];            // Expected csb rise per byte of one refresh

    logic [15:0] vec_mem   [0:VEC_MAX-1];
    logic [9:0]  init_word [0:VEC_MAX-1];  // {end, dc, byte}
    logic [9:0]  tail_word [0:VEC_MAX-1];
    pat_sel_t    sel_list  [0:VEC_MAX-1];
    logic        sel_quiet [0:VEC_MAX-1];  // Selection must give no refresh
    int          init_count = 0;
    int          tail_count = 0;
    int          sel_count = 0;

    eink_driver_top #(
        .DISPLAY_BYTES(DISPLAY_BYTES),
        .DELAY_TICKS(DELAY_TICKS),
        .DELAY_LOOPS(DELAY_LOOPS),
        .SCK_DIV(SCK_DIV)
    ) dut (
        .clk(clk), .rst_n(rst_n), .pat_sel(pat_sel), .panel_busy(panel_busy),
        .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_csb(spi_csb),
        .panel_dc(panel_dc), .panel_rst_n(panel_rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    always @(negedge panel_rst_n) rst_pulses++;  // Hardware reset pulses seen

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Lowest set selection bit picks the pattern
    function automatic byte_t pattern_byte(input pat_sel_t sel, input int addr);
        logic [15:0] a;
        int          lowest;
        int          b;
        a = 16'(addr);
        lowest = -1;
        for (b = 5; b >= 0; b--) begin
            if (sel[b]) lowest = b;
        end
        case (lowest)
            PAT_WHITE:   return 8'hFF;
            PAT_BLACK:   return 8'h00;
            PAT_VSTRIPE: return {8{a[7]}};
            PAT_HSTRIPE: return {8{a[0]}};
            PAT_CHECK_S: return {8{a[0] ^ a[6]}};
            PAT_CHECK_L: return {8{a[2] ^ a[8]}};
            default:     return 8'hFF;
        endcase
    endfunction

    task automatic load_vectors();
        int i;
        for (i = 0; i < VEC_MAX; i++) vec_mem[i] = '0;
        $readmemh("tb/eink_vectors.txt", vec_mem);
        for (i = 0; i < VEC_MAX; i++) begin
            case (vec_mem[i][15:12])
                4'h1: begin
                    init_word[init_count] = vec_mem[i][9:0];
                    init_count++;
                end
                4'h2: begin
                    tail_word[tail_count] = vec_mem[i][9:0];
                    tail_count++;
                end
                4'h3, 4'h4: begin
                    sel_list[sel_count]  = vec_mem[i][5:0];
                    sel_quiet[sel_count] = (vec_mem[i][15:12] == 4'h4);
                    sel_count++;
                end
                default: ;  // Unused word
            endcase
        end
        check_value(32'(init_count), 32'd30, "init bytes in vector file");
        check_value(32'(tail_count), 32'd5, "tail bytes in vector file");
    endtask

    task automatic expect_byte(input byte_t data, input logic dc, input logic last,
                               input string what);
        int idx;
        wait (rx_count > rx_rd);
        idx = rx_rd;
        rx_rd++;
        check_value(32'(rx_data[idx]), 32'(data), {what, " value"});
        check_value(32'(rx_dc[idx]), 32'(dc), {what, " dc"});
        exp_end_q.push_back(last);  // csb rise checked once the refresh is over
    endtask

    task automatic run_refresh(input pat_sel_t sel);
        int base;
        int base_pulses;
        int k;
        check_value(32'(rx_count - rx_rd), 32'd0, "stray bytes before refresh");
        base = rx_rd;
        base_pulses = rst_pulses;
        exp_end_q.delete();
        @(posedge clk);
        #1;
        pat_sel = sel;
        expect_byte(SOFT_RESET_BYTE, 1'b0, 1'b1, "soft reset");
        check_value(32'(rst_pulses - base_pulses), 32'd1, "panel reset pulses");
        check_value(32'(panel_rst_n), 32'd1, "panel reset released");
        for (k = 0; k < init_count; k++) begin
            expect_byte(init_word[k][7:0], init_word[k][8], init_word[k][9],
                        $sformatf("init byte %0d", k));
        end
        for (k = 0; k < DISPLAY_BYTES; k++) begin
            expect_byte(pattern_byte(sel, k), 1'b1, k == DISPLAY_BYTES - 1,
                        $sformatf("pixel %0d of selection 0x%0h", k, sel));
        end
        for (k = 0; k < tail_count; k++) begin
            expect_byte(tail_word[k][7:0], tail_word[k][8], tail_word[k][9],
                        $sformatf("tail byte %0d", k));
        end
        wait (spi_csb == 1'b1);
        repeat (4) @(posedge clk);
        for (k = 0; k < exp_end_q.size(); k++) begin
            check_value(32'(rx_end[base + k]), 32'(exp_end_q[k]),
                        $sformatf("csb rise after byte %0d of refresh", k));
        end
    endtask

    task automatic check_quiet(input pat_sel_t sel);
        int base_count;
        int base_pulses;
        base_count = rx_count;
        base_pulses = rst_pulses;
        @(posedge clk);
        #1;
        pat_sel = sel;
        repeat (QUIET_CYCLES) @(posedge clk);
        check_value(32'(rx_count - base_count), 32'd0,
                    $sformatf("bytes after selection 0x%0h", sel));
        check_value(32'(rst_pulses - base_pulses), 32'd0, "panel reset without refresh");
        check_value(32'(spi_csb), 32'd1, "csb idle in quiet window");
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    // Mode 0 receiver, bits taken on SCK rise, frame end on csb rise
    initial begin : spi_receiver
        byte_t shift;
        int    nbits;
        shift = '0;
        nbits = 0;
        forever begin
            @(posedge spi_sck or posedge spi_csb);
            if (spi_csb === 1'b1) begin
                if (nbits != 0) begin
                    $display("SPI frame closed in the middle of a byte at %0t ns", $time);
                    errors++;
                    nbits = 0;
                end
                if (rx_count > 0 && rx_count <= RX_MAX) rx_end[rx_count - 1] = 1'b1;
            end else begin
                if (nbits == 0) check_value(32'(panel_busy), 32'd0, "byte started while busy");
                shift = {shift[6:0], spi_mosi};  // MSB first
                nbits++;
                if (nbits == 8) begin
                    if (rx_count < RX_MAX) begin
                        rx_data[rx_count] = shift;
                        rx_dc[rx_count]   = panel_dc;
                        rx_end[rx_count]  = 1'b0;
                    end
                    rx_count++;
                    nbits = 0;
                end
            end
        end
    end

    // Panel goes busy after soft reset and master activate
    initial begin : busy_model
        int    seen;
        int    hold;
        byte_t last_byte;
        panel_busy = 1'b0;
        seen = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rx_count > seen && rx_count <= RX_MAX) begin
                seen = rx_count;
                last_byte = rx_data[seen - 1];
                if (!rx_dc[seen - 1] && (last_byte == 8'h12 || last_byte == 8'h20)) begin
                    hold = 20 + int'((lcg_next() >> 16) % 32'd64);
                    panel_busy = 1'b1;
                    repeat (hold) @(posedge clk);
                    #1;
                    panel_busy = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        #1;  // Vector file is read at time zero
        limit = sel_count * (DISPLAY_BYTES + 40) * 16 * SCK_DIV * 2;
        repeat (limit) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", limit);
        errors++;
        finish_run();
    end

    initial begin : main_seq
        int i;
        rst_n = 1'b0;
        pat_sel = '0;
        load_vectors();
        if (sel_count == 0) begin
            $display("Vector file holds no pattern selections");
            errors++;
            finish_run();
        end else begin
            repeat (16) @(posedge clk);
            #1;
            rst_n = 1'b1;
            repeat (8) @(posedge clk);
            check_value(32'(spi_csb), 32'd1, "csb after reset");
            check_value(32'(panel_rst_n), 32'd1, "panel reset after reset");
            check_value(32'(spi_sck), 32'd0, "SCK after reset");
            check_value(32'(panel_dc), 32'd1, "dc after reset");
            check_value(32'(rx_count), 32'd0, "bytes after reset");
            for (i = 0; i < sel_count; i++) begin
                if (sel_quiet[i])
                    check_quiet(sel_list[i]);
                else
                    run_refresh(sel_list[i]);
            end
            finish_run();
        end
    end

endmodule

`default_nettype wire

//--- tb/eink_vectors.txt
// Words: kind[15:12] (1 init byte, 2 tail byte, 3 refresh selection, 4 quiet selection)
// Bytes: bit 9 csb rises after it, bit 8 dc, bits 7:0 value. Selections: bits 5:0
// Init table, data entry, border, VCOM, gate and source voltages
1011 1303 103C 1305 102C 1336
1003 1317 1004 1141 1100 1332
// RAM X and Y counters, X window
104E 1300 104F 1100 1300 1044
1100 130F 1045 1100 1100 11F9
// Y window end, driver output control, write RAM opens the pixel frame
1300 1001 11F9 1100 1300 1024
// Tail: update control, master activate, deep sleep
2022 23F4 2220 2010 2301
// Selections: white, black, black again, vertical stripes, zero, vertical again
3001 3002 4002 3004 4000 4004
// Horizontal stripes, small checker, large checker, several bits set
3008 3010 3020 302C
